// File: testbench/bridge_stim.txt
# op adr data expected, all hex
# W write, R read and compare, S status compare, P poll not empty, Q quiet cycles in data
S 1 00000000 00000001
Q 0 00000005 00000000
W 0 a5a50001 00000000
W 0 a5a50002 00000000
W 0 a5a50003 00000000
P 1 00000000 00000000
Q 0 00000004 00000000
S 1 00000000 00030000
R 0 00000000 a5a50001
R 0 00000000 a5a50002
R 0 00000000 a5a50003
S 1 00000000 00030001
W 1 deadbeef 00000000
S 1 00000000 00030001
R 0 00000000 00000000
S 1 00000000 00030001
W 0 ffffffff 00000000
P 1 00000000 00000000
R 0 00000000 ffffffff
Q 0 00000002 00000000
S 1 00000000 00040009
W 0 5a000001 00000000
W 0 5a000002 00000000
W 0 5a000003 00000000
W 0 5a000004 00000000
W 0 5a000005 00000000
W 0 5a000006 00000000
W 0 5a000007 00000000
W 0 5a000008 00000000
W 0 5a000009 00000000
W 0 5a00000a 00000000
W 0 5a00000b 00000000
W 0 5a00000c 00000000
W 0 5a00000d 00000000
W 0 5a00000e 00000000
W 0 5a00000f 00000000
W 0 5a000010 00000000
W 0 5a000011 00000000
Q 0 00000004 00000000
S 1 00000000 000c000e
R 0 00000000 5a000001
R 0 00000000 5a000002
R 0 00000000 5a000003
R 0 00000000 5a000004
R 0 00000000 5a000005
R 0 00000000 5a000006
R 0 00000000 5a000007
R 0 00000000 5a000008
R 0 00000000 5a000009
R 0 00000000 5a00000a
R 0 00000000 5a00000b
R 0 00000000 5a00000c
R 0 00000000 5a00000d
R 0 00000000 5a00000e
R 0 00000000 5a00000f
R 0 00000000 5a000010
R 0 00000000 00000000
S 1 00000000 0014000d

// File: src.f
hdl/bridge_pkg.sv
hdl/msg_fifo.sv
hdl/msg_relay.sv
hdl/wb_host_port.sv
hdl/host_bridge_top.sv
testbench/tb_host_bridge.sv

// File: testbench/tb_host_bridge.sv
`timescale 1ns/1ps

module tb_host_bridge
  import bridge_pkg::*;
();

  logic    bus_clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  int   errors;
  logic stim_loaded;

  // One entry per stimulus line
  byte         op_q[$];
  logic [31:0] adr_q[$];
  logic [31:0] dat_q[$];
  logic [31:0] exp_q[$];

  host_bridge_top #(.depth(8)) UUT (
    .bus_clk(bus_clk),
    .rst(rst),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
  );

  initial begin
    bus_clk = 1'b0;
  end

  always #5 bus_clk = ~bus_clk;

  // *******************************************************************
  // Stimulus file and bus helpers
  // *******************************************************************

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("testbench/bridge_stim.txt", "r");
    assert (fd != 0) else begin
      $display("stimulus file testbench/bridge_stim.txt could not be opened");
      errors++;
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%c %h %h %h", op, a, d, e);
        // Comment and blank lines give fewer than four fields
        if (n == 4) begin
          op_q.push_back(op);
          adr_q.push_back(a);
          dat_q.push_back(d);
          exp_q.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  // Starts and returns on a falling edge
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input msg_t wdata,
                           output msg_t rdata);
    int wait_cycles;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr[0];
    wb_req.dat_w = wdata;
    wait_cycles  = 0;
    do begin
      @(negedge bus_clk);
      wait_cycles++;
    end while (!wb_rsp.ack && wait_cycles < 8);
    assert (wb_rsp.ack) else begin
      $display("no acknowledge from bridge");
      errors++;
    end
    rdata      = wb_rsp.dat_r;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    @(negedge bus_clk);
    assert (!wb_rsp.ack) else begin
      $display("bridge gave a second acknowledge for one request");
      errors++;
    end
  endtask

  task automatic check_word(input string name, input msg_t got, input msg_t exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n) begin
      @(negedge bus_clk);
      assert (!wb_rsp.ack) else begin
        $display("acknowledge seen while no request was on the bus");
        errors++;
      end
    end
  endtask

  // Relay latency varies, so STATUS is polled
  task automatic poll_not_empty();
    msg_t           rdata;
    bridge_status_t status_word;
    int             polls;
    polls = 0;
    do begin
      bus_cycle(1'b0, addr_status, '0, rdata);
      status_word = rdata;
      polls++;
    end while (status_word.rd_empty && polls < 20);
    assert (!status_word.rd_empty) else begin
      $display("read FIFO still empty after %0d status polls", polls);
      errors++;
    end
  endtask

  // *******************************************************************
  // Main sequence and watchdog
  // *******************************************************************

  initial begin
    msg_t rdata;
    errors      = 0;
    stim_loaded = 1'b0;
    rst         = 1'b1;
    wb_req      = '0;
    load_stim();
    stim_loaded = 1'b1;
    repeat (10) @(negedge bus_clk);
    rst = 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": bus_cycle(1'b1, adr_q[i], dat_q[i], rdata);
        "R": begin
          bus_cycle(1'b0, adr_q[i], '0, rdata);
          check_word("dat_r", rdata, exp_q[i]);
        end
        "S": begin
          bus_cycle(1'b0, adr_q[i], '0, rdata);
          check_word("status", rdata, exp_q[i]);
        end
        "P": poll_not_empty();
        "Q": quiet_cycles(dat_q[i]);
        default: begin
          assert (0) else begin
            $display("unknown operation on stimulus entry %0d", i);
            errors++;
          end
        end
      endcase
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Budget of 40 cycles per stimulus line on top of the reset cycles
  initial begin
    wait (stim_loaded);
    repeat (op_q.size() * 40 + 10) @(posedge bus_clk);
    $display("watchdog expired before the stimulus completed");
    errors++;
    $display("errors: %0d", errors);
    $display("test failed");
    $finish;
  end

endmodule

// File: hdl/host_bridge_top.sv
`timescale 1ns/1ps

module host_bridge_top
  import bridge_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic    bus_clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  // Host to write FIFO
  logic       wr_push;
  msg_t       wr_data;
  logic       wr_full;
  logic       wr_overflow;

  // Write FIFO to relay
  logic       wr_empty;
  msg_t       wr_head;
  logic       wr_pop;

  // Relay to read FIFO
  logic       rd_push;
  msg_t       rd_push_data;
  logic       rd_full;

  // Read FIFO to host
  msg_t       rd_head;
  logic       rd_empty;
  logic       rd_pop;

  logic       eof;
  msg_count_t msg_count;

  msg_fifo #(.depth(depth)) wr_fifo (
    .bus_clk(bus_clk), .rst(rst),
    .push(wr_push), .push_data(wr_data), .pop(wr_pop),
    .pop_data(wr_head), .empty(wr_empty), .full(wr_full), .overflow(wr_overflow)
  );

  msg_relay relay (
    .bus_clk(bus_clk), .rst(rst),
    .src_empty(wr_empty), .src_data(wr_head), .src_pop(wr_pop),
    .dst_full(rd_full), .dst_push(rd_push), .dst_data(rd_push_data),
    .eof(eof), .msg_count(msg_count)
  );

  // Relay never pushes when full, so overflow stays unused here
  msg_fifo #(.depth(depth)) rd_fifo (
    .bus_clk(bus_clk), .rst(rst),
    .push(rd_push), .push_data(rd_push_data), .pop(rd_pop),
    .pop_data(rd_head), .empty(rd_empty), .full(rd_full), .overflow()
  );

  wb_host_port host_port (
    .bus_clk(bus_clk), .rst(rst),
    .wb_req(wb_req), .wb_rsp(wb_rsp),
    .wr_push(wr_push), .wr_data(wr_data),
    .wr_full(wr_full), .wr_overflow(wr_overflow),
    .rd_data(rd_head), .rd_empty(rd_empty), .rd_pop(rd_pop),
    .eof(eof), .msg_count(msg_count)
  );

endmodule

// File: hdl/wb_host_port.sv
`timescale 1ns/1ps

module wb_host_port
  import bridge_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,

  // Write FIFO side
  output logic       wr_push,
  output msg_t       wr_data,
  input  logic       wr_full,
  input  logic       wr_overflow,

  // Read FIFO side
  input  msg_t       rd_data,
  input  logic       rd_empty,
  output logic       rd_pop,

  // From the relay
  input  logic       eof,
  input  msg_count_t msg_count
);

  logic           ack_q;
  msg_t           dat_r_q;
  logic           req_take;
  logic           is_data;
  msg_t           rd_word;
  bridge_status_t status;

  // *******************************************************************
  // Request decode
  // *******************************************************************

  // A request is taken once; the ack cycle masks it
  assign req_take = wb_req.cyc && wb_req.stb && !ack_q;
  assign is_data  = (wb_req.adr == addr_data);

  // Side effects happen on the sampling edge
  assign wr_push = req_take && wb_req.we && is_data;
  assign wr_data = wb_req.dat_w;

  // Reads of an empty DATA register pop nothing
  assign rd_pop = req_take && !wb_req.we && is_data && !rd_empty;

  // Status word assembly
  always_comb begin
    status             = '0;
    status.msg_count   = msg_count;
    status.eof         = eof;
    status.wr_overflow = wr_overflow;
    status.wr_full     = wr_full;
    status.rd_empty    = rd_empty;
  end

  always_comb begin
    case (wb_req.adr)
      addr_data:   rd_word = rd_empty ? '0 : rd_data;
      addr_status: rd_word = status;
      default:     rd_word = '0;
    endcase
  end

  // *******************************************************************
  // Response
  // *******************************************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_take;
    end
  end

  // Read data is captured before the pop moves the FIFO head
  always_ff @(posedge bus_clk) begin
    if (req_take && !wb_req.we) begin
      dat_r_q <= rd_word;
    end
  end

  assign wb_rsp = '{ack: ack_q, dat_r: dat_r_q};

  // Master keeps the request up until it is acknowledged
  a_req_held: assert property (
    @(posedge bus_clk) disable iff (rst) $fell(wb_req.stb) |-> wb_rsp.ack
  ) else $error("wb_host_port: request withdrawn before ack");

endmodule

// File: hdl/msg_relay.sv
`timescale 1ns/1ps

module msg_relay
  import bridge_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst,

  // Write FIFO, the source
  input  logic       src_empty,
  input  msg_t       src_data,
  output logic       src_pop,

  // Read FIFO, the destination
  input  logic       dst_full,
  output logic       dst_push,
  output msg_t       dst_data,

  // Stream state for the host
  output logic       eof,
  output msg_count_t msg_count
);

  logic move;
  logic is_marker;

  // *******************************************************************
  // Transfer
  // *******************************************************************

  // One word per cycle when there is a word and room for it
  assign move = !src_empty && !dst_full;

  assign src_pop  = move;
  assign dst_push = move;

  // Marker is forwarded like any other word
  assign dst_data = src_data;

  assign is_marker = (src_data == end_marker);

  // *******************************************************************
  // Bookkeeping
  // *******************************************************************

  // Counter wraps at 2**16
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      msg_count <= '0;
    end else if (move) begin
      msg_count <= msg_count + 1'b1;
    end
  end

  // End of stream stays set until reset
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      eof <= 1'b0;
    end else if (move && is_marker) begin
      eof <= 1'b1;
    end
  end

  // Head of a non-empty write FIFO always holds a written word
  a_known_word: assert property (
    @(posedge bus_clk) disable iff (rst) move |-> !$isunknown(src_data)
  ) else $error("msg_relay: unknown word relayed");

endmodule

// File: hdl/msg_fifo.sv
`timescale 1ns/1ps

module msg_fifo
  import bridge_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic bus_clk,
  input  logic rst,
  input  logic push,
  input  msg_t push_data,
  input  logic pop,
  output msg_t pop_data,
  output logic empty,
  output logic full,
  output logic overflow
);

  localparam int ptr_width = $clog2(depth);

  // Message storage
  msg_t mem [depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 do_push;
  logic                 do_pop;

  assign empty = (count == '0);
  assign full  = (count == (ptr_width + 1)'(depth));

  // A push into a full buffer is dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head word is presented without a register stage
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until reset
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

  // The reader must look at empty before popping
  a_no_pop_when_empty: assert property (
    @(posedge bus_clk) disable iff (rst) pop |-> !empty
  ) else $error("msg_fifo: pop while empty");

endmodule

// File: hdl/bridge_pkg.sv
package bridge_pkg;

  // *******************************************************************
  // Message words
  // *******************************************************************
  parameter int msg_width = 32;

  typedef logic [msg_width-1:0] msg_t;

  // All-ones word closes a stream
  parameter msg_t end_marker = '1;

  // Relayed word count that wraps
  typedef logic [15:0] msg_count_t;

  // *******************************************************************
  // Wishbone register port
  // *******************************************************************
  typedef logic [0:0] wb_adr_t;

  parameter wb_adr_t addr_data   = 1'b0;
  parameter wb_adr_t addr_status = 1'b1;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    msg_t    dat_w;
  } wb_req_t;

  typedef struct packed {
    logic ack;
    msg_t dat_r;
  } wb_rsp_t;

  // Word returned at the STATUS address
  typedef struct packed {
    msg_count_t  msg_count;
    logic [11:0] reserved;
    logic        eof;
    logic        wr_overflow;
    logic        wr_full;
    logic        rd_empty;
  } bridge_status_t;

endpackage
